/* include/simt_settings.svh */
`ifndef SIMT_SETTINGS_SVH
`define SIMT_SETTINGS_SVH

// ==================================================
// core geometry
// ==================================================

// warps per core
`define SIMT_NUM_WARPS 8

// threads per warp, also the active mask width
`define SIMT_NUM_THREADS 8

// instruction address width
`define SIMT_PC_WIDTH 10

// reconvergence entries per warp
`define SIMT_STACK_DEPTH 4

`endif

/* source/simt_pkg.sv */
`default_nettype none

`include "simt_settings.svh"

package simt_pkg;

    // ==================================================
    // decode side
    // ==================================================

    // one decode slot, at most one type flag set
    typedef struct packed {
        logic [`SIMT_NUM_WARPS-1:0] warp_valid;
        logic                       beq;
        logic                       blt;
        logic                       sync;
        logic                       call;
        logic                       ret;
        logic                       jmp;
        logic [`SIMT_PC_WIDTH-1:0]  pc_plus4;
    } decode_slot_t;

    // everything a single warp sees in one cycle
    typedef struct packed {
        logic                         load;
        logic [`SIMT_NUM_THREADS-1:0] load_mask;
        logic                         cond_br;
        logic                         sync;
        logic                         call;
        logic                         ret;
        logic                         jmp;
        logic [`SIMT_PC_WIDTH-1:0]    pc_plus4;
        logic                         outcome_valid;
        logic [`SIMT_NUM_THREADS-1:0] outcome;
    } warp_event_t;

    // ==================================================
    // reconvergence stack
    // ==================================================

    typedef enum logic [1:0] {
        kind_else   = 2'd0,
        kind_rejoin = 2'd1,
        kind_return = 2'd2
    } entry_kind_t;

    // mask is what runs next, rejoin_mask what ran before the split
    typedef struct packed {
        entry_kind_t                  kind;
        logic [`SIMT_PC_WIDTH-1:0]    pc;
        logic [`SIMT_NUM_THREADS-1:0] mask;
        logic [`SIMT_NUM_THREADS-1:0] rejoin_mask;
    } stack_entry_t;

endpackage

`default_nettype wire

/* source/simt_event_route.sv */
`default_nettype none

`include "simt_settings.svh"

module simt_event_route (
    // task manager
    input  wire                                  tm_update,
    input  wire  [$clog2(`SIMT_NUM_WARPS)-1:0]   tm_warp_id,
    input  wire  [`SIMT_NUM_THREADS-1:0]         tm_mask,
    // decode
    input  wire  simt_pkg::decode_slot_t         id_slot0,
    input  wire  simt_pkg::decode_slot_t         id_slot1,
    // alu branch outcome
    input  wire                                  alu_br,
    input  wire  [$clog2(`SIMT_NUM_WARPS)-1:0]   alu_warp_id,
    input  wire  [`SIMT_NUM_THREADS-1:0]         alu_outcome,
    // one event word per warp
    output simt_pkg::warp_event_t [`SIMT_NUM_WARPS-1:0] warp_events
);

    localparam int num_warps = `SIMT_NUM_WARPS;

    logic [num_warps-1:0] tm_hit;
    logic [num_warps-1:0] alu_hit;

    // decode side fields of one slot, beq and blt both stall the warp
    function automatic simt_pkg::warp_event_t fold_slot(input simt_pkg::decode_slot_t slot);
        simt_pkg::warp_event_t ev;
        ev          = '0;
        ev.cond_br  = slot.beq | slot.blt;
        ev.sync     = slot.sync;
        ev.call     = slot.call;
        ev.ret      = slot.ret;
        ev.jmp      = slot.jmp;
        ev.pc_plus4 = slot.pc_plus4;
        return ev;
    endfunction

    // warp ids to one-hot
    assign tm_hit  = tm_update ? (num_warps'(1) << tm_warp_id) : '0;
    assign alu_hit = alu_br ? (num_warps'(1) << alu_warp_id) : '0;

    always_comb begin
        for (int w = 0; w < num_warps; w++) begin
            // slot 0 wins when both slots name this warp
            if (id_slot0.warp_valid[w]) begin
                warp_events[w] = fold_slot(id_slot0);
            end else if (id_slot1.warp_valid[w]) begin
                warp_events[w] = fold_slot(id_slot1);
            end else begin
                warp_events[w] = '0;
            end

            warp_events[w].load          = tm_hit[w];
            warp_events[w].load_mask     = tm_mask;
            warp_events[w].outcome_valid = alu_hit[w];
            warp_events[w].outcome       = alu_outcome;
        end
    end

endmodule

`default_nettype wire

/* source/simt_stack.sv */
`default_nettype none

`include "simt_settings.svh"

module simt_stack #(
    parameter int depth = `SIMT_STACK_DEPTH
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         clear,
    input  wire                         push,
    input  wire                         pop,
    input  wire                         write_top,
    input  wire  simt_pkg::stack_entry_t wr_entry,
    output simt_pkg::stack_entry_t      top,
    output logic                        empty,
    output logic                        full
);

    localparam int ptr_w = $clog2(depth + 1);
    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    simt_pkg::stack_entry_t entries [depth];

    // number of valid entries, next free slot
    logic [ptr_w-1:0] ptr;
    logic [idx_w-1:0] top_idx;
    logic [idx_w-1:0] free_idx;
    logic             do_pop;
    logic             do_rewrite;
    logic             do_push;

    assign empty    = (ptr == '0);
    assign full     = (ptr == ptr_w'(depth));
    assign top_idx  = idx_w'(ptr - 1'b1);
    assign free_idx = idx_w'(ptr);

    // clear, then pop, then rewrite, then push
    assign do_pop     = !clear && pop && !empty;
    assign do_rewrite = !clear && !pop && write_top && !empty;
    assign do_push    = !clear && !pop && !write_top && push && !full;

    // top is visible in the same cycle it was written
    assign top = empty ? '0 : entries[top_idx];

    // ==================================================
    // pointer
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            ptr <= '0;
        end else if (do_pop) begin
            ptr <= ptr - 1'b1;
        end else if (do_push) begin
            ptr <= ptr + 1'b1;
        end
    end

    // ==================================================
    // entry storage
    // ==================================================

    always_ff @(posedge clk) begin
        if (do_rewrite) begin
            entries[top_idx] <= wr_entry;
        end else if (do_push) begin
            entries[free_idx] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

/* source/simt_warp_ctrl.sv */
`default_nettype none

`include "simt_settings.svh"

module simt_warp_ctrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire   simt_pkg::warp_event_t  warp_event,
    // toward fetch
    output logic                          qual1,
    output logic                          qual2,
    output logic                          stall,
    output logic [`SIMT_PC_WIDTH-1:0]     target_pc,
    // toward the instruction buffer
    output logic                          drop,
    output logic [`SIMT_NUM_THREADS-1:0]  active_mask
);

    // stack command and status
    logic                   stk_clear;
    logic                   stk_push;
    logic                   stk_pop;
    logic                   stk_write_top;
    simt_pkg::stack_entry_t stk_entry;
    simt_pkg::stack_entry_t stk_top;
    logic                   stk_empty;

    // taken and not-taken threads of the current outcome
    logic [`SIMT_NUM_THREADS-1:0] taken;
    logic [`SIMT_NUM_THREADS-1:0] not_taken;

    // pc_plus4 of the branch that stalled the warp
    logic [`SIMT_PC_WIDTH-1:0]    branch_pc;

    // next state
    logic [`SIMT_NUM_THREADS-1:0] mask_d;
    logic [`SIMT_PC_WIDTH-1:0]    target_d;
    logic [`SIMT_PC_WIDTH-1:0]    branch_pc_d;
    logic                         stall_d;
    logic                         redirect_d;
    logic                         qual2_d;

    logic top_is_else;
    logic top_is_rejoin;
    logic top_is_return;

    assign taken     = active_mask & warp_event.outcome;
    assign not_taken = active_mask & ~warp_event.outcome;

    assign top_is_else   = !stk_empty && (stk_top.kind == simt_pkg::kind_else);
    assign top_is_rejoin = !stk_empty && (stk_top.kind == simt_pkg::kind_rejoin);
    assign top_is_return = !stk_empty && (stk_top.kind == simt_pkg::kind_return);

    // ==================================================
    // event rules
    // ==================================================

    always_comb begin
        stk_clear     = 1'b0;
        stk_push      = 1'b0;
        stk_pop       = 1'b0;
        stk_write_top = 1'b0;
        stk_entry     = '0;
        mask_d        = active_mask;
        target_d      = target_pc;
        branch_pc_d   = branch_pc;
        stall_d       = stall;
        redirect_d    = 1'b0;
        qual2_d       = 1'b0;

        if (warp_event.load) begin
            // fresh warp from the task manager
            mask_d    = warp_event.load_mask;
            stk_clear = 1'b1;
        end else if (warp_event.outcome_valid) begin
            stall_d = 1'b0;
            if (|taken && |not_taken) begin
                // split, taken side first, else side parked on the stack
                stk_push              = 1'b1;
                stk_entry.kind        = simt_pkg::kind_else;
                stk_entry.pc          = branch_pc;
                stk_entry.mask        = not_taken;
                stk_entry.rejoin_mask = active_mask;
                mask_d                = taken;
                qual2_d               = 1'b1;
            end else if (|taken) begin
                qual2_d = 1'b1;
            end
        end else if (warp_event.cond_br) begin
            // hold fetch until the alu answers
            stall_d     = 1'b1;
            branch_pc_d = warp_event.pc_plus4;
        end else if (warp_event.sync) begin
            if (top_is_else) begin
                // switch to the else path, keep the entry for the rejoin
                mask_d         = stk_top.mask;
                target_d       = stk_top.pc;
                redirect_d     = 1'b1;
                stk_write_top  = 1'b1;
                stk_entry      = stk_top;
                stk_entry.kind = simt_pkg::kind_rejoin;
            end else if (top_is_rejoin) begin
                stk_pop = 1'b1;
                mask_d  = stk_top.rejoin_mask;
            end
        end else if (warp_event.call) begin
            stk_push              = 1'b1;
            stk_entry.kind        = simt_pkg::kind_return;
            stk_entry.pc          = warp_event.pc_plus4;
            stk_entry.mask        = active_mask;
            stk_entry.rejoin_mask = active_mask;
            qual2_d               = 1'b1;
        end else if (warp_event.ret) begin
            if (top_is_return) begin
                stk_pop    = 1'b1;
                mask_d     = stk_top.mask;
                target_d   = stk_top.pc;
                redirect_d = 1'b1;
            end
        end else if (warp_event.jmp) begin
            qual2_d = 1'b1;
        end
    end

    // ==================================================
    // registered outputs
    // ==================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_mask <= '0;
            target_pc   <= '0;
            branch_pc   <= '0;
            stall       <= 1'b0;
            qual1       <= 1'b0;
            qual2       <= 1'b0;
            drop        <= 1'b0;
        end else begin
            active_mask <= mask_d;
            target_pc   <= target_d;
            branch_pc   <= branch_pc_d;
            stall       <= stall_d;
            // a redirect always flushes the buffered instructions too
            qual1       <= redirect_d;
            drop        <= redirect_d;
            qual2       <= qual2_d;
        end
    end

    simt_stack #(
        .depth(`SIMT_STACK_DEPTH)
    ) i_stack (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (stk_clear),
        .push     (stk_push),
        .pop      (stk_pop),
        .write_top(stk_write_top),
        .wr_entry (stk_entry),
        .top      (stk_top),
        .empty    (stk_empty),
        .full     ()
    );

endmodule

`default_nettype wire

/* source/simt_unit.sv */
`default_nettype none

`include "simt_settings.svh"

module simt_unit (
    input  wire                                  clk,
    input  wire                                  rst_n,
    // task manager
    input  wire                                  tm_update,
    input  wire  [$clog2(`SIMT_NUM_WARPS)-1:0]   tm_warp_id,
    input  wire  [`SIMT_NUM_THREADS-1:0]         tm_mask,
    // decode
    input  wire  simt_pkg::decode_slot_t         id_slot0,
    input  wire  simt_pkg::decode_slot_t         id_slot1,
    // alu
    input  wire                                  alu_br,
    input  wire  [$clog2(`SIMT_NUM_WARPS)-1:0]   alu_warp_id,
    input  wire  [`SIMT_NUM_THREADS-1:0]         alu_outcome,
    // fetch
    output logic [`SIMT_NUM_WARPS-1:0]           upd_pc_qual1,
    output logic [`SIMT_NUM_WARPS-1:0]           upd_pc_qual2,
    output logic [`SIMT_NUM_WARPS-1:0]           stall,
    output logic [`SIMT_NUM_WARPS-1:0][`SIMT_PC_WIDTH-1:0]    target_pc,
    // instruction buffer
    output logic [`SIMT_NUM_WARPS-1:0]           drop_instr,
    output logic [`SIMT_NUM_WARPS-1:0][`SIMT_NUM_THREADS-1:0] active_mask
);

    simt_pkg::warp_event_t [`SIMT_NUM_WARPS-1:0] warp_events;

    // ==================================================
    // event routing
    // ==================================================

    simt_event_route i_route (
        .tm_update  (tm_update),
        .tm_warp_id (tm_warp_id),
        .tm_mask    (tm_mask),
        .id_slot0   (id_slot0),
        .id_slot1   (id_slot1),
        .alu_br     (alu_br),
        .alu_warp_id(alu_warp_id),
        .alu_outcome(alu_outcome),
        .warp_events(warp_events)
    );

    // ==================================================
    // per-warp controllers
    // ==================================================

    // warp w drives bit w and word w of every output vector
    for (genvar w = 0; w < `SIMT_NUM_WARPS; w++) begin : g_warp
        simt_warp_ctrl i_warp_ctrl (
            .clk        (clk),
            .rst_n      (rst_n),
            .warp_event (warp_events[w]),
            .qual1      (upd_pc_qual1[w]),
            .qual2      (upd_pc_qual2[w]),
            .stall      (stall[w]),
            .target_pc  (target_pc[w]),
            .drop       (drop_instr[w]),
            .active_mask(active_mask[w])
        );
    end

endmodule

`default_nettype wire

/* verification/simt_unit_tb.sv */
`default_nettype none

`include "simt_settings.svh"

module simt_unit_tb;

    localparam int num_warps   = `SIMT_NUM_WARPS;
    localparam int num_threads = `SIMT_NUM_THREADS;
    localparam int pc_w        = `SIMT_PC_WIDTH;
    localparam int stack_depth = `SIMT_STACK_DEPTH;
    localparam int warp_id_w   = $clog2(num_warps);

    // decode slot opcodes
    localparam int op_beq  = 1;
    localparam int op_blt  = 2;
    localparam int op_sync = 3;
    localparam int op_call = 4;
    localparam int op_ret  = 5;
    localparam int op_jmp  = 6;

    logic                   clk;
    logic                   rst_n;
    logic                   tm_update;
    logic [warp_id_w-1:0]   tm_warp_id;
    logic [num_threads-1:0] tm_mask;
    simt_pkg::decode_slot_t id_slot0;
    simt_pkg::decode_slot_t id_slot1;
    logic                   alu_br;
    logic [warp_id_w-1:0]   alu_warp_id;
    logic [num_threads-1:0] alu_outcome;

    logic [num_warps-1:0]                  upd_pc_qual1;
    logic [num_warps-1:0]                  upd_pc_qual2;
    logic [num_warps-1:0]                  stall;
    logic [num_warps-1:0][pc_w-1:0]        target_pc;
    logic [num_warps-1:0]                  drop_instr;
    logic [num_warps-1:0][num_threads-1:0] active_mask;

    // ==================================================
    // reference model state
    // ==================================================

    logic [num_threads-1:0] ref_mask      [num_warps];
    logic [pc_w-1:0]        ref_target    [num_warps];
    logic [pc_w-1:0]        ref_branch_pc [num_warps];
    logic [num_warps-1:0]   ref_stall;
    logic [num_warps-1:0]   ref_q1;
    logic [num_warps-1:0]   ref_q2;
    logic [num_warps-1:0]   ref_drop;
    simt_pkg::stack_entry_t ref_stack  [num_warps][stack_depth];
    int                     ref_depth  [num_warps];

    logic [31:0] rng;
    int          value_errors;
    int          timeouts;

    simt_unit i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .tm_update   (tm_update),
        .tm_warp_id  (tm_warp_id),
        .tm_mask     (tm_mask),
        .id_slot0    (id_slot0),
        .id_slot1    (id_slot1),
        .alu_br      (alu_br),
        .alu_warp_id (alu_warp_id),
        .alu_outcome (alu_outcome),
        .upd_pc_qual1(upd_pc_qual1),
        .upd_pc_qual2(upd_pc_qual2),
        .stall       (stall),
        .target_pc   (target_pc),
        .drop_instr  (drop_instr),
        .active_mask (active_mask)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic simt_pkg::decode_slot_t slot_for(input int w, input int op,
                                                        input logic [pc_w-1:0] pc);
        simt_pkg::decode_slot_t s;
        s               = '0;
        s.warp_valid[w] = 1'b1;
        s.beq           = (op == op_beq);
        s.blt           = (op == op_blt);
        s.sync          = (op == op_sync);
        s.call          = (op == op_call);
        s.ret           = (op == op_ret);
        s.jmp           = (op == op_jmp);
        s.pc_plus4      = pc;
        return s;
    endfunction

    function automatic simt_pkg::stack_entry_t entry_of(input simt_pkg::entry_kind_t kind,
        input logic [pc_w-1:0] pc, input logic [num_threads-1:0] mask,
        input logic [num_threads-1:0] rejoin_mask);
        simt_pkg::stack_entry_t e;
        e.kind        = kind;
        e.pc          = pc;
        e.mask        = mask;
        e.rejoin_mask = rejoin_mask;
        return e;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            value_errors++;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic check_outputs();
        for (int w = 0; w < num_warps; w++) begin
            check_value(upd_pc_qual1[w], ref_q1[w], $sformatf("warp %0d qual1", w));
            check_value(upd_pc_qual2[w], ref_q2[w], $sformatf("warp %0d qual2", w));
            check_value(drop_instr[w], ref_drop[w], $sformatf("warp %0d drop", w));
            check_value(stall[w], ref_stall[w], $sformatf("warp %0d stall", w));
            check_value(target_pc[w], ref_target[w], $sformatf("warp %0d target_pc", w));
            check_value(active_mask[w], ref_mask[w], $sformatf("warp %0d active_mask", w));
        end
    endtask

    // the inputs still hold what the DUT sampled on this edge
    task automatic apply_event();
        simt_pkg::decode_slot_t slot;
        simt_pkg::stack_entry_t top;
        logic [num_threads-1:0] t;
        logic [num_threads-1:0] n;
        for (int w = 0; w < num_warps; w++) begin
            ref_q1[w]   = 1'b0;
            ref_q2[w]   = 1'b0;
            ref_drop[w] = 1'b0;
            if (id_slot0.warp_valid[w]) begin
                slot = id_slot0;
            end else if (id_slot1.warp_valid[w]) begin
                slot = id_slot1;
            end else begin
                slot = '0;
            end
            top = (ref_depth[w] > 0) ? ref_stack[w][ref_depth[w]-1] : '0;
            if (tm_update && tm_warp_id == w) begin
                ref_mask[w]  = tm_mask;
                ref_depth[w] = 0;
            end else if (alu_br && alu_warp_id == w) begin
                ref_stall[w] = 1'b0;
                t = ref_mask[w] & alu_outcome;
                n = ref_mask[w] & ~alu_outcome;
                if (t != '0 && n != '0) begin
                    ref_stack[w][ref_depth[w]] = entry_of(simt_pkg::kind_else,
                                                          ref_branch_pc[w], n, ref_mask[w]);
                    ref_depth[w]++;
                    ref_mask[w] = t;
                    ref_q2[w]   = 1'b1;
                end else if (t != '0) begin
                    ref_q2[w] = 1'b1;
                end
            end else if (slot.beq || slot.blt) begin
                ref_stall[w]     = 1'b1;
                ref_branch_pc[w] = slot.pc_plus4;
            end else if (slot.sync && ref_depth[w] > 0) begin
                if (top.kind == simt_pkg::kind_else) begin
                    ref_mask[w]   = top.mask;
                    ref_target[w] = top.pc;
                    ref_q1[w]     = 1'b1;
                    ref_drop[w]   = 1'b1;
                    ref_stack[w][ref_depth[w]-1].kind = simt_pkg::kind_rejoin;
                end else if (top.kind == simt_pkg::kind_rejoin) begin
                    ref_depth[w]--;
                    ref_mask[w] = top.rejoin_mask;
                end
            end else if (slot.call) begin
                ref_stack[w][ref_depth[w]] = entry_of(simt_pkg::kind_return, slot.pc_plus4,
                                                      ref_mask[w], ref_mask[w]);
                ref_depth[w]++;
                ref_q2[w] = 1'b1;
            end else if (slot.ret && ref_depth[w] > 0) begin
                if (top.kind == simt_pkg::kind_return) begin
                    ref_depth[w]--;
                    ref_mask[w]   = top.mask;
                    ref_target[w] = top.pc;
                    ref_q1[w]     = 1'b1;
                    ref_drop[w]   = 1'b1;
                end
            end else if (slot.jmp) begin
                ref_q2[w] = 1'b1;
            end
        end
    endtask

    // ==================================================
    // cycle drivers
    // ==================================================

    task automatic drive(input logic tm_u, input logic [warp_id_w-1:0] tm_w,
        input logic [num_threads-1:0] tm_m, input simt_pkg::decode_slot_t s0,
        input simt_pkg::decode_slot_t s1, input logic ab, input logic [warp_id_w-1:0] aw,
        input logic [num_threads-1:0] ao);
        tm_update   <= tm_u;
        tm_warp_id  <= tm_w;
        tm_mask     <= tm_m;
        id_slot0    <= s0;
        id_slot1    <= s1;
        alu_br      <= ab;
        alu_warp_id <= aw;
        alu_outcome <= ao;
    endtask

    task automatic run_cycle(input logic tm_u, input logic [warp_id_w-1:0] tm_w,
        input logic [num_threads-1:0] tm_m, input simt_pkg::decode_slot_t s0,
        input simt_pkg::decode_slot_t s1, input logic ab, input logic [warp_id_w-1:0] aw,
        input logic [num_threads-1:0] ao);
        @(posedge clk);
        apply_event();
        drive(tm_u, tm_w, tm_m, s0, s1, ab, aw, ao);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, '0, '0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic decode_cycle(input simt_pkg::decode_slot_t s0,
                                input simt_pkg::decode_slot_t s1);
        run_cycle(1'b0, '0, '0, s0, s1, 1'b0, '0, '0);
    endtask

    task automatic wait_stall(input int w);
        int n;
        n = 0;
        while (!stall[w] && n < 8) begin
            idle_cycle();
            n++;
        end
        if (!stall[w]) begin
            timeouts++;
            $display("timeout: warp %0d never raised stall after its branch", w);
        end
    endtask

    // one random op, pushes only while the stack has room to spare
    function automatic simt_pkg::decode_slot_t random_slot(input int w);
        logic [31:0] r;
        int          op;
        r  = rand_next();
        op = 1 + (r % 6);
        if ((op == op_beq || op == op_blt || op == op_call) && ref_depth[w] >= stack_depth - 1) begin
            op = op_jmp;
        end
        return slot_for(w, op, r[16+:pc_w]);
    endfunction

    task automatic random_cycle();
        logic [31:0]            r;
        logic [num_warps-1:0]   busy;
        logic                   tm_u;
        logic                   ab;
        logic [warp_id_w-1:0]   tm_w;
        logic [warp_id_w-1:0]   aw;
        logic [warp_id_w-1:0]   w0;
        logic [warp_id_w-1:0]   w1;
        logic [num_threads-1:0] tm_m;
        logic [num_threads-1:0] ao;
        simt_pkg::decode_slot_t s0;
        simt_pkg::decode_slot_t s1;
        @(posedge clk);
        apply_event();
        busy = ref_stall;
        {tm_u, tm_w, tm_m, ab, aw, ao} = '0;
        s0 = '0;
        s1 = '0;
        r = rand_next();
        if (r % 10 == 0 && !busy[r[8+:warp_id_w]]) begin
            tm_u = 1'b1;
            tm_w = r[8+:warp_id_w];
            tm_m = r[16+:num_threads];
            busy[tm_w] = 1'b1;
        end
        // outcomes go only to stalled warps
        r = rand_next();
        for (int i = 0; i < num_warps; i++) begin
            if (r[12] && !ab && ref_stall[(r[2:0] + i) % num_warps]) begin
                ab = 1'b1;
                aw = warp_id_w'((r[2:0] + i) % num_warps);
                ao = r[16+:num_threads];
            end
        end
        r  = rand_next();
        w0 = r[warp_id_w-1:0];
        if (r[5:4] != 2'd0 && !busy[w0]) begin
            s0 = random_slot(w0);
            busy[w0] = 1'b1;
        end
        r  = rand_next();
        w1 = r[warp_id_w-1:0];
        if (s0.warp_valid != '0 && r[5:4] == 2'd0) begin
            // shadowed by slot 0
            s1 = random_slot(w0);
        end else if (r[6] && !busy[w1]) begin
            s1 = random_slot(w1);
        end
        drive(tm_u, tm_w, tm_m, s0, s1, ab, aw, ao);
        @(negedge clk);
        check_outputs();
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        rng          = 32'h50c3;
        value_errors = 0;
        timeouts     = 0;
        rst_n        = 1'b0;
        drive(1'b0, '0, '0, '0, '0, 1'b0, '0, '0);
        ref_stall = '0;
        ref_q1    = '0;
        ref_q2    = '0;
        ref_drop  = '0;
        for (int w = 0; w < num_warps; w++) begin
            ref_mask[w]      = '0;
            ref_target[w]    = '0;
            ref_branch_pc[w] = '0;
            ref_depth[w]     = 0;
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;

        // reset values, then two loads
        idle_cycle();
        run_cycle(1'b1, 3'd2, 8'hff, '0, '0, 1'b0, '0, '0);
        run_cycle(1'b1, 3'd5, 8'h3c, '0, '0, 1'b0, '0, '0);
        idle_cycle();

        // uniform branches, all taken then none taken
        decode_cycle(slot_for(2, op_beq, 10'h010), '0);
        wait_stall(2);
        run_cycle(1'b0, '0, '0, '0, '0, 1'b1, 3'd2, 8'hff);
        decode_cycle(slot_for(2, op_blt, 10'h020), '0);
        wait_stall(2);
        run_cycle(1'b0, '0, '0, '0, '0, 1'b1, 3'd2, 8'h00);
        idle_cycle();

        // split, the else path resumes at the branch's own pc_plus4
        decode_cycle(slot_for(2, op_beq, 10'h044), '0);
        wait_stall(2);
        run_cycle(1'b0, '0, '0, '0, '0, 1'b1, 3'd2, 8'h0f);
        decode_cycle(slot_for(2, op_sync, 10'h080), '0);
        decode_cycle(slot_for(2, op_sync, 10'h0c0), '0);
        idle_cycle();

        // call, jump, return, then ignored return and sync on empty stacks
        decode_cycle(slot_for(5, op_call, 10'h120), '0);
        decode_cycle(slot_for(5, op_jmp, 10'h200), '0);
        decode_cycle(slot_for(5, op_ret, 10'h204), '0);
        decode_cycle(slot_for(5, op_ret, 10'h208), slot_for(6, op_sync, 10'h300));
        // slot 0 wins over slot 1 on the same warp
        decode_cycle(slot_for(5, op_jmp, 10'h000), slot_for(5, op_beq, 10'h004));
        idle_cycle();

        for (int i = 0; i < 500; i++) begin
            random_cycle();
        end
        idle_cycle();
        idle_cycle();

        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
source/simt_pkg.sv
source/simt_event_route.sv
source/simt_stack.sv
source/simt_warp_ctrl.sv
source/simt_unit.sv
verification/simt_unit_tb.sv

/* Bender.yml */
package:
  name: simt_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/simt_pkg.sv
      - source/simt_event_route.sv
      - source/simt_stack.sv
      - source/simt_warp_ctrl.sv
      - source/simt_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/simt_unit_tb.sv
